// File: Bender.yml
package:
  name: calc_core

sources:
  # Shared package first, then units, controller and top level
  - common/calc_pkg.sv
  - src/add_sub_unit.sv
  - src/shift_add_mult.sv
  - calc_ctrl/calc_ctrl.sv
  - src/calc_top.sv
  - target: test
    files:
      - testbench/tb_calc_top.sv

// File: calc_ctrl/calc_ctrl.sv
`default_nettype none

module calc_ctrl (
    input  logic              clk,
    input  logic              nRST,

    input  calc_pkg::digit_t  keypad_input,    // Digit value from keypad
    input  logic              read_input,      // Digit strobe
    input  calc_pkg::op_sel_t operator_input,  // Operator strobe when nonzero
    input  logic              equal_input,     // Equal strobe

    // Add/subtract unit
    output calc_pkg::word_t   alu_a,
    output calc_pkg::word_t   alu_b,
    output logic              alu_sub,         // 1 selects a - b
    output logic              alu_start,
    input  calc_pkg::word_t   alu_result,
    input  logic              alu_finish,

    // Shared multiplier
    output calc_pkg::word_t   mult_a,
    output calc_pkg::word_t   mult_b,
    output logic              mult_start,
    input  calc_pkg::word_t   mult_result,
    input  logic              mult_finish,

    output logic              complete,        // One-cycle result pulse
    output calc_pkg::word_t   display_output,  // Held until next result
    output logic              busy             // Key presses ignored while high
);
    import calc_pkg::*;

    typedef enum logic [2:0] {
        ENTER_OP1,   // Building first operand
        ENTER_OP2,   // Building second operand, operator latched
        SHIFT_WAIT,  // Operand times ten in the multiplier
        CALC_WAIT,   // Waiting on the selected unit
        SHOW         // Result shown, clearing for next entry
    } state_t;

    state_t state, next_state;

    word_t   operand1, operand2;
    op_sel_t op_latched;
    logic    ext_op2;       // Operand being extended is operand2
    digit_t  digit_hold;    // Digit added when the shift returns

    logic  entering;
    logic  op_valid;
    logic  digit_accept;
    logic  op_accept;
    logic  equal_accept;
    logic  unit_done;
    word_t calc_result;

    assign entering = (state == ENTER_OP1) || (state == ENTER_OP2);
    assign op_valid = operator_input inside {OP_ADD, OP_SUB, OP_MUL};

    // Strobe priority within one cycle is digit, then operator, then equal
    assign digit_accept = entering && read_input;
    assign op_accept    = entering && !read_input && op_valid;
    assign equal_accept = (state == ENTER_OP2) && !read_input && !op_valid && equal_input;

    // Multiply results come back through the shared multiplier
    assign unit_done   = (op_latched == OP_MUL) ? mult_finish : alu_finish;
    assign calc_result = (op_latched == OP_MUL) ? mult_result : alu_result;

    assign busy = !entering;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= ENTER_OP1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ENTER_OP1: begin
                if (digit_accept) begin
                    next_state = SHIFT_WAIT;
                end else if (op_accept) begin
                    next_state = ENTER_OP2;
                end
            end
            ENTER_OP2: begin
                if (digit_accept) begin
                    next_state = SHIFT_WAIT;
                end else if (equal_accept) begin
                    next_state = CALC_WAIT;
                end
            end
            SHIFT_WAIT: begin
                if (mult_finish) begin
                    next_state = ext_op2 ? ENTER_OP2 : ENTER_OP1;
                end
            end
            CALC_WAIT: begin
                if (unit_done) begin
                    next_state = SHOW;
                end
            end
            SHOW:    next_state = ENTER_OP1;
            default: next_state = ENTER_OP1;
        endcase
    end

    // Control and operand registers
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand1       <= '0;
            operand2       <= '0;
            op_latched     <= '0;
            ext_op2        <= 1'b0;
            mult_start     <= 1'b0;
            alu_start      <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            mult_start <= 1'b0;   // Strobes last one cycle
            alu_start  <= 1'b0;
            complete   <= 1'b0;
            case (state)
                ENTER_OP1, ENTER_OP2: begin
                    if (digit_accept) begin
                        mult_start <= 1'b1;                  // Operand times ten
                        ext_op2    <= (state == ENTER_OP2);
                    end else if (op_accept) begin
                        op_latched <= operator_input;        // Later one replaces it
                    end else if (equal_accept) begin
                        if (op_latched == OP_MUL) begin
                            mult_start <= 1'b1;
                        end else begin
                            alu_start <= 1'b1;
                        end
                    end
                end
                SHIFT_WAIT: begin
                    if (mult_finish) begin
                        if (ext_op2) begin
                            operand2 <= mult_result + word_t'(digit_hold);
                        end else begin
                            operand1 <= mult_result + word_t'(digit_hold);
                        end
                    end
                end
                CALC_WAIT: begin
                    if (unit_done) begin
                        complete       <= 1'b1;
                        display_output <= calc_result;
                    end
                end
                SHOW: begin
                    // Fresh start for the next calculation
                    operand1   <= '0;
                    operand2   <= '0;
                    op_latched <= '0;
                    ext_op2    <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // Operand routing to the units, sampled by them on the start cycle
    always_ff @(posedge clk) begin
        if (digit_accept) begin
            mult_a     <= (state == ENTER_OP2) ? operand2 : operand1;
            mult_b     <= word_t'(10);
            digit_hold <= keypad_input;
        end else if (equal_accept) begin
            mult_a  <= operand1;
            mult_b  <= operand2;
            alu_a   <= operand1;
            alu_b   <= operand2;
            alu_sub <= (op_latched == OP_SUB);
        end
    end

endmodule

`default_nettype wire

// File: common/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // Datapath width, also used for counter sizing
    localparam int WORD_W = 16;

    // Operand, result and display value
    typedef logic [WORD_W-1:0] word_t;

    // One keypad digit, 0 to 9 in normal use
    typedef logic [3:0] digit_t;

    // One-hot operator select
    typedef logic [2:0] op_sel_t;

    localparam op_sel_t OP_ADD = 3'b001;   // Addition
    localparam op_sel_t OP_SUB = 3'b010;   // Subtraction, wraps below zero
    localparam op_sel_t OP_MUL = 3'b100;   // Multiplication, low 16 bits kept

endpackage

`default_nettype wire

// File: flist.f
common/calc_pkg.sv
src/add_sub_unit.sv
src/shift_add_mult.sv
calc_ctrl/calc_ctrl.sv
src/calc_top.sv
testbench/tb_calc_top.sv

// File: src/add_sub_unit.sv
`default_nettype none

module add_sub_unit #(
    parameter int SLICE_W = 4   // Bits per cycle, divides WORD_W
) (
    input  logic            clk,
    input  logic            nRST,
    input  calc_pkg::word_t a,
    input  calc_pkg::word_t b,
    input  logic            sub,      // 1 gives a - b
    input  logic            start,
    output calc_pkg::word_t result,
    output logic            finish
);
    import calc_pkg::*;

    localparam int NUM_SLICES = WORD_W / SLICE_W;
    localparam int CNT_W      = $clog2(NUM_SLICES + 1);

    word_t             a_sh, b_sh;     // Remaining operand slices
    logic              carry;          // Carry between slices
    logic              running;
    logic [CNT_W-1:0]  slice_cnt;

    word_t             src_a, src_b;
    logic              src_c;
    logic [SLICE_W:0]  slice_sum;

    // The start cycle already adds slice 0 straight from the inputs
    assign src_a = start ? a : a_sh;
    assign src_b = start ? (sub ? ~b : b) : b_sh;   // Two's complement via inverted b
    assign src_c = start ? sub : carry;             // Plus one when subtracting

    assign slice_sum = {1'b0, src_a[SLICE_W-1:0]} + {1'b0, src_b[SLICE_W-1:0]}
                     + (SLICE_W + 1)'(src_c);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running   <= 1'b0;
            slice_cnt <= '0;
            finish    <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                slice_cnt <= CNT_W'(1);
                running   <= (NUM_SLICES > 1);
                finish    <= (NUM_SLICES == 1);
            end else if (running) begin
                slice_cnt <= slice_cnt + 1'b1;
                if (slice_cnt == CNT_W'(NUM_SLICES - 1)) begin
                    running <= 1'b0;        // Last slice this cycle
                    finish  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || running) begin
            a_sh   <= src_a >> SLICE_W;
            b_sh   <= src_b >> SLICE_W;
            carry  <= slice_sum[SLICE_W];
            result <= word_t'({slice_sum[SLICE_W-1:0], result} >> SLICE_W);  // Fill from top
        end
    end

endmodule

`default_nettype wire

// File: src/calc_top.sv
`default_nettype none

module calc_top #(
    parameter int SLICE_W = 4   // Adder slice width
) (
    input  logic              clk,
    input  logic              nRST,
    input  calc_pkg::digit_t  keypad_input,
    input  logic              read_input,
    input  calc_pkg::op_sel_t operator_input,
    input  logic              equal_input,
    output logic              complete,
    output calc_pkg::word_t   display_output,
    output logic              busy
);
    import calc_pkg::*;

    word_t alu_a, alu_b, alu_result;
    logic  alu_sub, alu_start, alu_finish;

    word_t mult_a, mult_b, mult_result;
    logic  mult_start, mult_finish;

    calc_ctrl u_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .alu_a          (alu_a),
        .alu_b          (alu_b),
        .alu_sub        (alu_sub),
        .alu_start      (alu_start),
        .alu_result     (alu_result),
        .alu_finish     (alu_finish),
        .mult_a         (mult_a),
        .mult_b         (mult_b),
        .mult_start     (mult_start),
        .mult_result    (mult_result),
        .mult_finish    (mult_finish),
        .complete       (complete),
        .display_output (display_output),
        .busy           (busy)
    );

    add_sub_unit #(
        .SLICE_W (SLICE_W)
    ) u_add_sub (
        .clk    (clk),
        .nRST   (nRST),
        .a      (alu_a),
        .b      (alu_b),
        .sub    (alu_sub),
        .start  (alu_start),
        .result (alu_result),
        .finish (alu_finish)
    );

    // Shared between times-ten digit entry and the multiply operator
    shift_add_mult u_mult (
        .clk    (clk),
        .nRST   (nRST),
        .a      (mult_a),
        .b      (mult_b),
        .start  (mult_start),
        .result (mult_result),
        .finish (mult_finish)
    );

endmodule

`default_nettype wire

// File: src/shift_add_mult.sv
`default_nettype none

module shift_add_mult (
    input  logic            clk,
    input  logic            nRST,
    input  calc_pkg::word_t a,       // Multiplicand
    input  calc_pkg::word_t b,       // Multiplier
    input  logic            start,
    output calc_pkg::word_t result,  // Low 16 bits of a * b
    output logic            finish
);
    import calc_pkg::*;

    localparam int CNT_W = $clog2(WORD_W);

    word_t             mcand;      // Shifted left each cycle
    word_t             mplier;     // Shifted right each cycle
    word_t             acc;
    logic              running;
    logic [CNT_W-1:0]  bit_cnt;

    word_t             src_mcand;
    word_t             src_mplier;
    word_t             src_acc;
    word_t             acc_next;

    // Bit 0 is handled on the start cycle from the inputs
    assign src_mcand  = start ? a : mcand;
    assign src_mplier = start ? b : mplier;
    assign src_acc    = start ? '0 : acc;

    assign acc_next = src_mplier[0] ? (src_acc + src_mcand) : src_acc;

    assign result = acc;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            bit_cnt <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                running <= 1'b1;
                bit_cnt <= CNT_W'(1);
            end else if (running) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CNT_W'(WORD_W - 1)) begin
                    running <= 1'b0;   // Top multiplier bit done
                    finish  <= 1'b1;
                end
            end
        end
    end

    // High product bits fall off the top of mcand
    always_ff @(posedge clk) begin
        if (start || running) begin
            mcand  <= src_mcand << 1;
            mplier <= src_mplier >> 1;
            acc    <= acc_next;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_calc_top.sv
`default_nettype none

module tb_calc_top;
    import calc_pkg::*;

    localparam int     MAX_CYCLES = 20000;   // ~40 calcs x 12 keys x 20 cycles, with margin
    localparam int     DONE_LIMIT = 200;     // Equal to complete
    localparam int     IDLE_LIMIT = 100;
    localparam int     DIGIT_BUSY = 17;      // Busy cycles after an accepted digit
    localparam longint WRAP       = longint'(1) << WORD_W;

    logic    clk;
    logic    nRST;
    digit_t  keypad_input;
    logic    read_input;
    op_sel_t operator_input;
    logic    equal_input;
    logic    complete;
    word_t   display_output;
    logic    busy;

    int      cycle_cnt;
    int      seed;

    calc_top #(
        .SLICE_W (4)
    ) u_dut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output),
        .busy           (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            report_failure($sformatf("Timeout, the run went past %0d cycles", MAX_CYCLES));
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED at time %0t: %s is %0d, expected %0d",
                                     $time, name, actual, expected));
        end
    endtask

    // Modulo 2^16 reference for one calculation
    function automatic longint model_result(input longint a, input longint b,
                                            input op_sel_t op);
        longint wa;
        longint wb;
        longint r;
        wa = a % WRAP;   // Operands wrap during entry
        wb = b % WRAP;
        case (op)
            OP_ADD:  r = (wa + wb) % WRAP;
            OP_SUB:  r = (wa - wb + WRAP) % WRAP;
            default: r = (wa * wb) % WRAP;
        endcase
        return r;
    endfunction

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy) begin
            n++;
            if (n > IDLE_LIMIT) begin
                report_failure("busy stayed high, the DUT never returned to entry");
            end
            @(negedge clk);
        end
    endtask

    task automatic press_digit(input digit_t d);
        int high_cycles;
        wait_idle();
        @(posedge clk);
        keypad_input <= d;
        read_input   <= 1'b1;
        @(posedge clk);
        read_input   <= 1'b0;
        high_cycles = 0;
        @(negedge clk);
        check("busy", busy, 1);   // Raised the cycle after acceptance
        while (busy) begin
            high_cycles++;
            if (high_cycles > IDLE_LIMIT) begin
                report_failure("busy did not fall after a digit was entered");
            end
            @(negedge clk);
        end
        check("busy cycles per digit", high_cycles, DIGIT_BUSY);
    endtask

    task automatic press_op(input op_sel_t op);
        wait_idle();
        @(posedge clk);
        operator_input <= op;
        @(posedge clk);
        operator_input <= '0;
    endtask

    task automatic press_equal();
        wait_idle();
        @(posedge clk);
        equal_input <= 1'b1;
        @(posedge clk);
        equal_input <= 1'b0;
    endtask

    // Most significant digit first
    task automatic enter_number(input int value);
        int digits[$];
        int v;
        v = value;
        do begin
            digits.push_front(v % 10);
            v = v / 10;
        end while (v > 0);
        foreach (digits[i]) begin
            press_digit(digit_t'(digits[i]));
        end
    endtask

    task automatic watch_no_complete(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk);
            if (complete) begin
                report_failure({"complete pulsed unexpectedly ", what});
            end
        end
    endtask

    task automatic expect_result(input logic [31:0] expected);
        int n;
        n = 0;
        @(negedge clk);
        while (!complete) begin
            n++;
            if (n > DONE_LIMIT) begin
                report_failure("No complete pulse within 200 cycles of equal");
            end
            @(negedge clk);
        end
        check("display_output", display_output, expected);
        watch_no_complete(20, "after a result");   // Exactly one pulse
        check("display_output held", display_output, expected);
    endtask

    task automatic run_calc(input int a, input op_sel_t op, input int b);
        enter_number(a);
        press_op(op);
        enter_number(b);
        press_equal();
        expect_result(model_result(a, b, op));
    endtask

    task automatic test_reset_idle();
        @(negedge clk);
        check("complete", complete, 0);
        check("busy", busy, 0);
        check("display_output", display_output, 0);
        press_equal();              // No operator latched yet
        watch_no_complete(50, "after a lone equal");
        check("busy", busy, 0);
        press_op(3'b011);           // Not one-hot
        press_op(3'b110);
        press_equal();              // Would start a unit if an operator had latched
        watch_no_complete(50, "after invalid operator strobes");
        check("busy", busy, 0);
    endtask

    task automatic test_add_sub();
        run_calc(123, OP_ADD, 456);
        check("display_output", display_output, 579);
        run_calc(500, OP_SUB, 123);
        check("display_output", display_output, 377);
        run_calc(5, OP_SUB, 9);
        check("display_output", display_output, 65532);   // Wraps below zero
    endtask

    task automatic test_mul();
        run_calc(12, OP_MUL, 34);
        check("display_output", display_output, 408);
        run_calc(300, OP_MUL, 300);
        check("display_output", display_output, 24464);
    endtask

    task automatic test_entry_wrap();
        run_calc(70000, OP_ADD, 0);
        check("display_output", display_output, 4464);
    endtask

    task automatic test_op_replace();
        enter_number(7);
        press_op(OP_ADD);
        enter_number(3);
        press_op(OP_MUL);           // Replaces add
        press_equal();
        expect_result(21);
        run_calc(4, OP_ADD, 5);     // Operands cleared after a result
        check("display_output", display_output, 9);
    endtask

    task automatic test_random();
        int      a;
        int      b;
        int      k;
        op_sel_t op;
        repeat (20) begin
            a = {$random(seed)} % 10000;
            b = {$random(seed)} % 10000;
            k = {$random(seed)} % 3;
            case (k)
                0:       op = OP_ADD;
                1:       op = OP_SUB;
                default: op = OP_MUL;
            endcase
            run_calc(a, op, b);
        end
    endtask

    initial begin
        seed           = 32'hbc584215;
        cycle_cnt      = 0;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        repeat (5) @(posedge clk);
        nRST <= 1'b1;

        test_reset_idle();
        test_add_sub();
        test_mul();
        test_entry_wrap();
        test_op_replace();
        test_random();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
